// File: verilog/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

    // --------------------
    // widths and counts
    // --------------------
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  beat_cnt_t;    // beats minus one
    typedef logic [1:0]  client_sel_t;

    localparam int unsigned NumClients  = 3;
    localparam int unsigned WOrderDepth = 4;   // writes in flight on W

    // index into every packed client array
    localparam client_sel_t SelDcache = 2'd0;
    localparam client_sel_t SelBypass = 2'd1;
    localparam client_sel_t SelIcache = 2'd2;

    localparam axi_id_t IdIcache     = 4'b0000;
    localparam axi_id_t IdDcache     = 4'b1100;
    localparam axi_id_t IdBypassBase = 4'b1000;  // 10xx

    // --------------------
    // channel payloads
    // --------------------
    typedef struct packed {
        axi_id_t   id;
        addr_t     addr;
        beat_cnt_t len;
    } ar_chan_t;

    typedef struct packed {
        axi_id_t   id;
        addr_t     addr;
        beat_cnt_t len;
    } aw_chan_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } w_chan_t;

    typedef struct packed {
        axi_id_t id;
        data_t   data;
        logic    last;
    } r_chan_t;

    typedef struct packed {
        axi_id_t id;
    } b_chan_t;

    // master side of a port, same shape for clients and bus
    typedef struct packed {
        ar_chan_t ar;
        logic     ar_valid;
        aw_chan_t aw;
        logic     aw_valid;
        w_chan_t  w;
        logic     w_valid;
        logic     r_ready;
        logic     b_ready;
    } port_req_t;

    typedef struct packed {
        logic     ar_ready;
        logic     aw_ready;
        logic     w_ready;
        r_chan_t  r;
        logic     r_valid;
        b_chan_t  b;
        logic     b_valid;
    } port_rsp_t;

    // fixed ID map
    function automatic client_sel_t decode_id(axi_id_t id);
        client_sel_t sel;
        case (id) inside
            IdIcache:                             sel = SelIcache;
            IdDcache:                             sel = SelDcache;
            [IdBypassBase : IdBypassBase + 4'd3]: sel = SelBypass;
            default:                              sel = SelDcache; // unmapped
        endcase
        return sel;
    endfunction

endpackage

`default_nettype wire

// File: verilog/rr_stream_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_stream_arbiter #(
    parameter type payload_t = logic
) (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    input  payload_t [cache_bus_pkg::NumClients-1:0]    inp_data_i,
    input  logic [cache_bus_pkg::NumClients-1:0]        inp_valid_i,
    output logic [cache_bus_pkg::NumClients-1:0]        inp_ready_o,
    output payload_t                                    oup_data_o,
    output logic                                        oup_valid_o,
    input  logic                                        oup_ready_i
);

    cache_bus_pkg::client_sel_t rr_ptr_q;   // highest priority client
    cache_bus_pkg::client_sel_t grant_q;    // held choice during a stall
    cache_bus_pkg::client_sel_t pick;
    cache_bus_pkg::client_sel_t grant;
    logic                       lock_q;
    logic                       found;

    // first valid client at or after the pointer
    always_comb begin : pick_next
        int unsigned idx;
        pick  = rr_ptr_q;
        found = 1'b0;
        for (int unsigned k = 0; k < cache_bus_pkg::NumClients; k++) begin
            idx = (int'(rr_ptr_q) + k) % cache_bus_pkg::NumClients;
            if (!found && inp_valid_i[idx]) begin
                pick  = cache_bus_pkg::client_sel_t'(idx);
                found = 1'b1;
            end
        end
    end

    assign grant       = lock_q ? grant_q : pick;
    assign oup_data_o  = inp_data_i[grant];
    assign oup_valid_o = inp_valid_i[grant];

    always_comb begin
        inp_ready_o        = '0;
        inp_ready_o[grant] = oup_ready_i;  // only the granted client sees ready
    end

    // --------------------
    // pointer and lock
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_ptr_q <= '0;
            grant_q  <= '0;
            lock_q   <= 1'b0;
        end else if (oup_valid_o && oup_ready_i) begin
            lock_q <= 1'b0;
            if (grant == cache_bus_pkg::client_sel_t'(cache_bus_pkg::NumClients - 1)) begin
                rr_ptr_q <= '0;
            end else begin
                rr_ptr_q <= grant + 2'd1;  // one past the winner
            end
        end else if (oup_valid_o) begin
            lock_q  <= 1'b1;                // bus stalled, keep this client
            grant_q <= grant;
        end
    end

endmodule

`default_nettype wire

// File: verilog/write_data_router.sv
`timescale 1ns/1ps
`default_nettype none

module write_data_router (
    input  logic                                                clk_i,
    input  logic                                                reset_i,
    // AW as seen on the bus
    input  cache_bus_pkg::aw_chan_t                             aw_i,
    input  logic                                                aw_valid_i,
    output logic                                                aw_ready_o,
    input  logic                                                aw_ready_i,
    // W from the clients
    input  cache_bus_pkg::w_chan_t [cache_bus_pkg::NumClients-1:0] w_i,
    input  logic [cache_bus_pkg::NumClients-1:0]                w_valid_i,
    output logic [cache_bus_pkg::NumClients-1:0]                w_ready_o,
    // W to the bus
    output cache_bus_pkg::w_chan_t                              w_o,
    output logic                                                w_valid_o,
    input  logic                                                w_ready_i
);

    localparam int unsigned PtrW = $clog2(cache_bus_pkg::WOrderDepth);

    typedef logic [PtrW-1:0] ptr_t;
    typedef logic [PtrW:0]   cnt_t;

    cache_bus_pkg::client_sel_t order_mem [cache_bus_pkg::WOrderDepth];
    ptr_t                       wr_ptr_q;
    ptr_t                       rd_ptr_q;
    cnt_t                       count_q;
    logic                       empty;
    logic                       full;
    logic                       push;
    logic                       pop;
    cache_bus_pkg::client_sel_t w_sel;

    assign empty = (count_q == '0);
    assign full  = (count_q == cnt_t'(cache_bus_pkg::WOrderDepth));

    // room left in the queue; the top masks AW requests with this,
    // so the bus never sees an AW that could not be recorded
    assign aw_ready_o = ~full;

    assign push = aw_valid_i & aw_ready_i;
    assign pop  = w_valid_o & w_ready_i & w_o.last & ~empty;

    // --------------------
    // write-order queue
    // --------------------
    always_ff @(posedge clk_i) begin
        if (push) begin
            order_mem[wr_ptr_q] <= cache_bus_pkg::decode_id(aw_i.id);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // --------------------
    // W mux
    // --------------------
    // icache never writes, so parking on it keeps bus W valid low
    assign w_sel = empty ? cache_bus_pkg::SelIcache : order_mem[rd_ptr_q];

    assign w_o       = w_i[w_sel];
    assign w_valid_o = w_valid_i[w_sel];

    always_comb begin
        w_ready_o        = '0;
        w_ready_o[w_sel] = w_ready_i;
    end

endmodule

`default_nettype wire

// File: verilog/resp_router.sv
`timescale 1ns/1ps
`default_nettype none

module resp_router (
    input  cache_bus_pkg::axi_id_t                      id_i,
    input  logic                                        valid_i,
    output logic                                        ready_o,
    output logic [cache_bus_pkg::NumClients-1:0]        valid_o,
    input  logic [cache_bus_pkg::NumClients-1:0]        ready_i
);

    cache_bus_pkg::client_sel_t sel;

    // unknown IDs end up at the data cache
    assign sel = cache_bus_pkg::decode_id(id_i);

    always_comb begin
        valid_o      = '0;
        valid_o[sel] = valid_i;
    end

    assign ready_o = ready_i[sel];   // backpressure from the addressed client

endmodule

`default_nettype wire

// File: verilog/mem_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_mux (
    input  logic                                                    clk_i,
    input  logic                                                    reset_i,
    input  cache_bus_pkg::port_req_t [cache_bus_pkg::NumClients-1:0] client_req_i,
    output cache_bus_pkg::port_rsp_t [cache_bus_pkg::NumClients-1:0] client_rsp_o,
    output cache_bus_pkg::port_req_t                                bus_req_o,
    input  cache_bus_pkg::port_rsp_t                                bus_rsp_i
);

    cache_bus_pkg::ar_chan_t [cache_bus_pkg::NumClients-1:0] ar_data;
    cache_bus_pkg::aw_chan_t [cache_bus_pkg::NumClients-1:0] aw_data;
    cache_bus_pkg::w_chan_t  [cache_bus_pkg::NumClients-1:0] w_data;
    logic [cache_bus_pkg::NumClients-1:0] ar_valid, ar_ready;
    logic [cache_bus_pkg::NumClients-1:0] aw_valid, aw_ready;
    logic [cache_bus_pkg::NumClients-1:0] w_valid, w_ready;
    logic [cache_bus_pkg::NumClients-1:0] r_valid, r_ready;
    logic [cache_bus_pkg::NumClients-1:0] b_valid, b_ready;

    cache_bus_pkg::ar_chan_t bus_ar;
    cache_bus_pkg::aw_chan_t bus_aw;
    cache_bus_pkg::w_chan_t  bus_w;
    logic bus_ar_valid, bus_aw_valid, bus_w_valid;
    logic bus_r_ready, bus_b_ready;
    logic aw_room;     // write-order queue not full

    // --------------------
    // client side
    // --------------------
    always_comb begin
        for (int i = 0; i < cache_bus_pkg::NumClients; i++) begin
            ar_data[i]  = client_req_i[i].ar;
            ar_valid[i] = client_req_i[i].ar_valid;
            aw_data[i]  = client_req_i[i].aw;
            aw_valid[i] = client_req_i[i].aw_valid & aw_room;
            w_data[i]   = client_req_i[i].w;
            w_valid[i]  = client_req_i[i].w_valid;
            r_ready[i]  = client_req_i[i].r_ready;
            b_ready[i]  = client_req_i[i].b_ready;

            client_rsp_o[i].ar_ready = ar_ready[i];
            client_rsp_o[i].aw_ready = aw_ready[i] & aw_room;  // held off while queue is full
            client_rsp_o[i].w_ready  = w_ready[i];
            client_rsp_o[i].r        = bus_rsp_i.r;   // broadcast
            client_rsp_o[i].r_valid  = r_valid[i];
            client_rsp_o[i].b        = bus_rsp_i.b;   // broadcast
            client_rsp_o[i].b_valid  = b_valid[i];
        end
    end

    // --------------------
    // bus side
    // --------------------
    always_comb begin
        bus_req_o.ar       = bus_ar;
        bus_req_o.ar_valid = bus_ar_valid;
        bus_req_o.aw       = bus_aw;
        bus_req_o.aw_valid = bus_aw_valid;
        bus_req_o.w        = bus_w;
        bus_req_o.w_valid  = bus_w_valid;
        bus_req_o.r_ready  = bus_r_ready;
        bus_req_o.b_ready  = bus_b_ready;
    end

    rr_stream_arbiter #(.payload_t(cache_bus_pkg::ar_chan_t)) ar_arb_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .inp_data_i  (ar_data),
        .inp_valid_i (ar_valid),
        .inp_ready_o (ar_ready),
        .oup_data_o  (bus_ar),
        .oup_valid_o (bus_ar_valid),
        .oup_ready_i (bus_rsp_i.ar_ready)
    );

    rr_stream_arbiter #(.payload_t(cache_bus_pkg::aw_chan_t)) aw_arb_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .inp_data_i  (aw_data),
        .inp_valid_i (aw_valid),
        .inp_ready_o (aw_ready),
        .oup_data_o  (bus_aw),
        .oup_valid_o (bus_aw_valid),
        .oup_ready_i (bus_rsp_i.aw_ready)
    );

    // W has no ID, so data follows the AW acceptance order
    write_data_router w_router_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .aw_i       (bus_aw),
        .aw_valid_i (bus_aw_valid),
        .aw_ready_o (aw_room),
        .aw_ready_i (bus_rsp_i.aw_ready),
        .w_i        (w_data),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .w_o        (bus_w),
        .w_valid_o  (bus_w_valid),
        .w_ready_i  (bus_rsp_i.w_ready)
    );

    resp_router r_router_inst (
        .id_i    (bus_rsp_i.r.id),
        .valid_i (bus_rsp_i.r_valid),
        .ready_o (bus_r_ready),
        .valid_o (r_valid),
        .ready_i (r_ready)
    );

    resp_router b_router_inst (
        .id_i    (bus_rsp_i.b.id),
        .valid_i (bus_rsp_i.b_valid),
        .ready_o (bus_b_ready),
        .valid_o (b_valid),
        .ready_i (b_ready)
    );

endmodule

`default_nettype wire

// File: tb/mem_port_mux_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_mux_checker (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  cache_bus_pkg::port_req_t bus_req_i,
    input  cache_bus_pkg::port_rsp_t bus_rsp_i,
    input  logic                     queue_empty_i
);

    int unsigned fail_count = 0;

    // --------------------
    // payload held during a stall
    // --------------------
    ar_held: assert property (@(posedge clk_i) disable iff (reset_i)
        bus_req_i.ar_valid && !bus_rsp_i.ar_ready |=>
            bus_req_i.ar_valid && $stable(bus_req_i.ar))
    else begin
        fail_count++;
        $error("bus AR dropped or changed while stalled");
    end

    aw_held: assert property (@(posedge clk_i) disable iff (reset_i)
        bus_req_i.aw_valid && !bus_rsp_i.aw_ready |=>
            bus_req_i.aw_valid && $stable(bus_req_i.aw))
    else begin
        fail_count++;
        $error("bus AW dropped or changed while stalled");
    end

    w_held: assert property (@(posedge clk_i) disable iff (reset_i)
        bus_req_i.w_valid && !bus_rsp_i.w_ready |=>
            bus_req_i.w_valid && $stable(bus_req_i.w))
    else begin
        fail_count++;
        $error("bus W dropped or changed while stalled");
    end

    // no W beat without a recorded write address
    w_needs_order: assert property (@(posedge clk_i) disable iff (reset_i)
        queue_empty_i |-> !bus_req_i.w_valid)
    else begin
        fail_count++;
        $error("bus W valid high while the order queue is empty");
    end

endmodule

bind mem_port_mux mem_port_mux_checker checker_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .bus_req_i     (bus_req_o),
    .bus_rsp_i     (bus_rsp_i),
    .queue_empty_i (w_router_inst.empty)
);

`default_nettype wire

// File: tb/mem_port_mux_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_mux_tb;

    typedef struct packed {
        logic [1:0]               client;    // 0 dcache, 1 bypass, 2 icache
        logic                     is_write;
        cache_bus_pkg::axi_id_t   id;
        cache_bus_pkg::addr_t     addr;
        cache_bus_pkg::beat_cnt_t len;
    } txn_t;

    localparam int NumRows = 12;

    // each client works through its own rows in order
    txn_t table_rows [NumRows] = '{
        '{2'd0, 1'b1, 4'b1100, 32'h0000_1000, 8'd3},
        '{2'd1, 1'b0, 4'b1000, 32'h0000_2000, 8'd0},
        '{2'd2, 1'b0, 4'b0000, 32'h0000_3000, 8'd7},
        '{2'd1, 1'b1, 4'b1001, 32'h0000_2100, 8'd1},
        '{2'd0, 1'b0, 4'b1100, 32'h0000_1100, 8'd3},
        '{2'd2, 1'b0, 4'b0000, 32'h0000_3100, 8'd3},
        '{2'd1, 1'b1, 4'b1010, 32'h0000_2200, 8'd0},
        '{2'd0, 1'b1, 4'b1100, 32'h0000_1200, 8'd7},
        '{2'd1, 1'b0, 4'b1011, 32'h0000_2300, 8'd2},
        '{2'd2, 1'b0, 4'b0000, 32'h0000_3200, 8'd1},
        '{2'd0, 1'b0, 4'b1100, 32'h0000_1300, 8'd0},
        '{2'd0, 1'b1, 4'b1100, 32'h0000_1400, 8'd1}
    };

    logic                                                    clk;
    logic                                                    reset;
    cache_bus_pkg::port_req_t [cache_bus_pkg::NumClients-1:0] client_req;
    cache_bus_pkg::port_rsp_t [cache_bus_pkg::NumClients-1:0] client_rsp;
    cache_bus_pkg::port_req_t                                bus_req;
    cache_bus_pkg::port_rsp_t                                bus_rsp;

    logic [31:0] lfsr_state = 32'hc6928296;
    int          error_count = 0;
    int          reads_done = 0;
    int          writes_done = 0;
    int          bus_ar_count = 0;
    int          bus_aw_count = 0;

    cache_bus_pkg::ar_chan_t rd_q [$];   // reads accepted by the slave
    cache_bus_pkg::aw_chan_t wr_q [$];   // writes in AW order
    cache_bus_pkg::axi_id_t  b_q [$];

    mem_port_mux mem_port_mux_inst (
        .clk_i        (clk),
        .reset_i      (reset),
        .client_req_i (client_req),
        .client_rsp_o (client_rsp),
        .bus_req_o    (bus_req),
        .bus_rsp_i    (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (NumRows * 200 + 50) @(posedge clk);
        $display("timeout: transactions did not complete in time");
        $display("Finished with errors");
        $finish;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic cache_bus_pkg::data_t beat_data(cache_bus_pkg::addr_t addr, int beat);
        return {~addr, addr + 32'(beat)};   // write pattern
    endfunction

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        error_count++;
        $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    // --------------------
    // memory slave
    // --------------------
    task automatic serve_bus_slave();
        int   r_beat;
        int   w_beat;
        logic ar_fire;
        logic aw_fire;
        logic w_fire;
        logic r_fire;
        logic b_fire;
        r_beat = 0;
        w_beat = 0;
        forever begin
            @(negedge clk);   // values seen by the next edge
            ar_fire = bus_req.ar_valid & bus_rsp.ar_ready;
            aw_fire = bus_req.aw_valid & bus_rsp.aw_ready;
            w_fire  = bus_req.w_valid & bus_rsp.w_ready;
            r_fire  = bus_rsp.r_valid & bus_req.r_ready;
            b_fire  = bus_rsp.b_valid & bus_req.b_ready;
            if (w_fire && wr_q.size() == 0) begin
                error_count++;
                $display("error at %0t: W beat on the bus with no accepted write", $time);
            end else if (w_fire) begin
                if (bus_req.w.data !== beat_data(wr_q[0].addr, w_beat))
                    report_mismatch("bus w.data", bus_req.w.data,
                                    beat_data(wr_q[0].addr, w_beat));
                if (bus_req.w.last !== (w_beat == int'(wr_q[0].len)))
                    report_mismatch("bus w.last", bus_req.w.last,
                                    w_beat == int'(wr_q[0].len));
                if (w_beat == int'(wr_q[0].len)) begin
                    b_q.push_back(wr_q[0].id);
                    void'(wr_q.pop_front());
                    w_beat = 0;
                end else begin
                    w_beat++;
                end
            end
            if (ar_fire) begin
                rd_q.push_back(bus_req.ar);
                bus_ar_count++;
            end
            if (aw_fire) begin
                wr_q.push_back(bus_req.aw);
                bus_aw_count++;
            end
            if (r_fire && bus_rsp.r.last) begin
                void'(rd_q.pop_front());
                r_beat = 0;
            end else if (r_fire) begin
                r_beat++;
            end
            if (b_fire) void'(b_q.pop_front());

            @(posedge clk);
            #2;
            bus_rsp.ar_ready = rand_bit() | rand_bit();
            bus_rsp.aw_ready = rand_bit() | rand_bit();
            bus_rsp.w_ready  = rand_bit() | rand_bit();
            if (!(bus_rsp.r_valid && !r_fire)) begin
                bus_rsp.r_valid = 1'b0;
                if (rd_q.size() > 0 && rand_bit()) begin
                    bus_rsp.r.id    = rd_q[0].id;
                    bus_rsp.r.data  = 64'(rd_q[0].addr) + 64'(r_beat);
                    bus_rsp.r.last  = (r_beat == int'(rd_q[0].len));
                    bus_rsp.r_valid = 1'b1;
                end
            end
            if (!(bus_rsp.b_valid && !b_fire)) begin
                bus_rsp.b_valid = 1'b0;
                if (b_q.size() > 0 && rand_bit()) begin
                    bus_rsp.b.id    = b_q[0];
                    bus_rsp.b_valid = 1'b1;
                end
            end
        end
    endtask

    // --------------------
    // client model
    // --------------------
    task automatic issue_client_rows(input int c);
        txn_t                 t;
        int                   beat;
        logic                 done;
        cache_bus_pkg::data_t exp_data;
        for (int n = 0; n < NumRows; n++) begin
            t = table_rows[n];
            if (int'(t.client) != c) continue;
            if (!t.is_write) begin
                client_req[c].ar       = '{t.id, t.addr, t.len};
                client_req[c].ar_valid = 1'b1;
                do begin
                    @(negedge clk);
                    done = client_rsp[c].ar_ready;
                    @(posedge clk);
                    #2;
                end while (!done);
                client_req[c].ar_valid = 1'b0;
                beat = 0;
                while (beat <= int'(t.len)) begin
                    client_req[c].r_ready = rand_bit() | rand_bit();
                    @(negedge clk);
                    if (client_rsp[c].r_valid && client_req[c].r_ready) begin
                        exp_data = 64'(t.addr) + 64'(beat);
                        if (client_rsp[c].r.id !== t.id)
                            report_mismatch($sformatf("client %0d r.id", c),
                                            client_rsp[c].r.id, t.id);
                        if (client_rsp[c].r.data !== exp_data)
                            report_mismatch($sformatf("client %0d r.data", c),
                                            client_rsp[c].r.data, exp_data);
                        if (client_rsp[c].r.last !== (beat == int'(t.len)))
                            report_mismatch($sformatf("client %0d r.last", c),
                                            client_rsp[c].r.last, beat == int'(t.len));
                        beat++;
                    end
                    @(posedge clk);
                    #2;
                end
                client_req[c].r_ready = 1'b0;
                reads_done++;
            end else begin
                client_req[c].aw       = '{t.id, t.addr, t.len};
                client_req[c].aw_valid = 1'b1;
                do begin
                    @(negedge clk);
                    done = client_rsp[c].aw_ready;
                    @(posedge clk);
                    #2;
                end while (!done);
                client_req[c].aw_valid = 1'b0;
                beat = 0;
                while (beat <= int'(t.len)) begin
                    client_req[c].w       = '{beat_data(t.addr, beat), beat == int'(t.len)};
                    client_req[c].w_valid = 1'b1;
                    @(negedge clk);
                    done = client_rsp[c].w_ready;
                    @(posedge clk);
                    #2;
                    if (done) beat++;
                end
                client_req[c].w_valid = 1'b0;
                done = 1'b0;
                while (!done) begin
                    client_req[c].b_ready = rand_bit() | rand_bit();
                    @(negedge clk);
                    done = client_rsp[c].b_valid & client_req[c].b_ready;
                    if (done && client_rsp[c].b.id !== t.id)
                        report_mismatch($sformatf("client %0d b.id", c),
                                        client_rsp[c].b.id, t.id);
                    @(posedge clk);
                    #2;
                end
                client_req[c].b_ready = 1'b0;
                writes_done++;
            end
        end
    endtask

    initial begin
        int   order [6];
        int   grant_count;
        int   winner;
        int   hits;
        int   exp_reads;
        int   exp_writes;
        int   beats;
        logic aw_done;
        reset      = 1'b1;
        client_req = '0;
        bus_rsp    = '0;
        exp_reads  = 0;
        exp_writes = 0;
        for (int n = 0; n < NumRows; n++) begin
            if (table_rows[n].is_write) exp_writes++;
            else exp_reads++;
        end
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        // idle bus after reset
        repeat (2) begin
            @(negedge clk);
            if (bus_req.ar_valid !== 1'b0) report_mismatch("bus ar_valid", bus_req.ar_valid, 0);
            if (bus_req.aw_valid !== 1'b0) report_mismatch("bus aw_valid", bus_req.aw_valid, 0);
            if (bus_req.w_valid !== 1'b0) report_mismatch("bus w_valid", bus_req.w_valid, 0);
        end
        @(posedge clk);
        #2;

        // --------------------
        // AR fairness with all three held through stalls
        // --------------------
        client_req[0].ar = '{4'b1100, 32'h0000_0100, 8'd0};
        client_req[1].ar = '{4'b1000, 32'h0000_0200, 8'd0};
        client_req[2].ar = '{4'b0000, 32'h0000_0300, 8'd0};
        for (int c = 0; c < 3; c++) client_req[c].ar_valid = 1'b1;
        grant_count = 0;
        while (grant_count < 6) begin
            bus_rsp.ar_ready = rand_bit();
            @(negedge clk);
            winner = 0;
            hits   = 0;
            for (int c = 0; c < 3; c++) begin
                if (client_rsp[c].ar_ready) begin
                    winner = c;
                    hits++;
                end
            end
            if (bus_rsp.ar_ready && hits != 1) begin
                error_count++;
                $display("error at %0t: %0d clients saw AR ready at once", $time, hits);
            end else if (bus_rsp.ar_ready) begin
                if (bus_req.ar.id !== client_req[winner].ar.id)
                    report_mismatch("bus ar.id", bus_req.ar.id, client_req[winner].ar.id);
                order[grant_count] = winner;
                grant_count++;
            end
            @(posedge clk);
            #2;
        end
        for (int k = 0; k < 6; k += 3) begin
            if (order[k] == order[k+1] || order[k] == order[k+2] ||
                order[k+1] == order[k+2]) begin
                error_count++;
                $display("error at %0t: AR grants %0d %0d %0d are not one per client",
                         $time, order[k], order[k+1], order[k+2]);
            end
        end
        for (int c = 0; c < 3; c++) client_req[c].ar_valid = 1'b0;
        bus_rsp.ar_ready = 1'b0;

        // unmapped response ID goes to the data cache only
        bus_rsp.r               = '{4'b0111, 64'h0, 1'b1};
        bus_rsp.r_valid         = 1'b1;
        bus_rsp.b.id            = 4'b0111;
        bus_rsp.b_valid         = 1'b1;
        client_req[0].r_ready   = 1'b1;
        client_req[0].b_ready   = 1'b1;
        @(negedge clk);
        for (int c = 0; c < 3; c++) begin
            if (client_rsp[c].r_valid !== (c == 0))
                report_mismatch($sformatf("client %0d r_valid", c), client_rsp[c].r_valid, c == 0);
            if (client_rsp[c].b_valid !== (c == 0))
                report_mismatch($sformatf("client %0d b_valid", c), client_rsp[c].b_valid, c == 0);
        end
        if (bus_req.r_ready !== 1'b1) report_mismatch("bus r_ready", bus_req.r_ready, 1);
        if (bus_req.b_ready !== 1'b1) report_mismatch("bus b_ready", bus_req.b_ready, 1);
        @(posedge clk);
        #2;
        bus_rsp    = '0;
        client_req = '0;

        // --------------------
        // write-order queue full
        // --------------------
        bus_rsp.aw_ready       = 1'b1;
        client_req[0].aw       = '{4'b1100, 32'h0000_0500, 8'd0};
        client_req[0].aw_valid = 1'b1;
        repeat (cache_bus_pkg::WOrderDepth) begin
            @(negedge clk);
            if (client_rsp[0].aw_ready !== 1'b1)
                report_mismatch("client 0 aw_ready", client_rsp[0].aw_ready, 1);
            @(posedge clk);
            #2;
        end
        // no W yet, so every slot is taken and client 1 has to wait
        client_req[0].aw_valid = 1'b0;
        client_req[1].aw       = '{4'b1000, 32'h0000_0600, 8'd0};
        client_req[1].aw_valid = 1'b1;
        repeat (2) begin
            @(negedge clk);
            if (client_rsp[1].aw_ready !== 1'b0)
                report_mismatch("client 1 aw_ready", client_rsp[1].aw_ready, 0);
            if (bus_req.aw_valid !== 1'b0)
                report_mismatch("bus aw_valid", bus_req.aw_valid, 0);
            @(posedge clk);
            #2;
        end
        // one beat per queued write, client 1 gets in on the first free slot
        client_req[0].w       = '{64'h0, 1'b1};
        client_req[0].w_valid = 1'b1;
        client_req[1].w       = '{64'h0, 1'b1};
        client_req[1].w_valid = 1'b1;
        bus_rsp.w_ready       = 1'b1;
        beats = 0;
        while (beats < cache_bus_pkg::WOrderDepth + 1) begin
            @(negedge clk);
            aw_done = client_rsp[1].aw_ready;
            if (bus_req.w_valid) beats++;
            @(posedge clk);
            #2;
            if (aw_done) client_req[1].aw_valid = 1'b0;
        end
        bus_rsp    = '0;
        client_req = '0;

        // table run against the slave model
        fork
            serve_bus_slave();
        join_none
        fork
            issue_client_rows(0);
            issue_client_rows(1);
            issue_client_rows(2);
        join
        repeat (4) @(posedge clk);

        error_count += int'(mem_port_mux_inst.checker_inst.fail_count);
        if (reads_done != exp_reads || bus_ar_count != exp_reads) begin
            error_count++;
            $display("error: %0d reads completed and %0d seen on the bus, table has %0d",
                     reads_done, bus_ar_count, exp_reads);
        end
        if (writes_done != exp_writes || bus_aw_count != exp_writes) begin
            error_count++;
            $display("error: %0d writes completed and %0d seen on the bus, table has %0d",
                     writes_done, bus_aw_count, exp_writes);
        end
        if (rd_q.size() != 0 || wr_q.size() != 0 || b_q.size() != 0) begin
            error_count++;
            $display("error: slave model still holds unfinished transactions");
        end
        $display("errors: %0d, reads %0d of %0d, writes %0d of %0d",
                 error_count, reads_done, exp_reads, writes_done, exp_writes);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/cache_bus_pkg.sv
verilog/rr_stream_arbiter.sv
verilog/write_data_router.sv
verilog/resp_router.sv
verilog/mem_port_mux.sv
tb/mem_port_mux_checker.sv
tb/mem_port_mux_tb.sv
